// ==== rtl/sramPkg.sv ====
`default_nettype none

package sramPkg;

	// --------------------------------------
	// SRAM geometry, 512K x 8
	// --------------------------------------
	localparam int RamAdrsWidth = 19;
	localparam int RamDqWidth = 8;

	// FIFO sizing
	localparam int FifoDepth = 16;
	localparam int FifoPtrWidth = $clog2(FifoDepth);
	// Count must hold FifoDepth itself
	localparam int FifoCountWidth = $clog2(FifoDepth + 1);

	// Beat count field, n means n+1 beats
	localparam int BurstLenWidth = 8;

	// Cycles from bus issue to read data in the phy
	localparam int PhyReadLatency = 2;

	typedef logic [RamAdrsWidth-1:0] ramAdrsT;
	typedef logic [RamDqWidth-1:0] ramDataT;

	// Read FIFO entry, 27 bits
	typedef struct packed {
		ramAdrsT adrs;
		ramDataT data;
	} readBeatT;

endpackage

`default_nettype wire

// ==== rtl/sramCmdIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// One SRAM access per clock, engine to phy
interface sramCmdIf
	import sramPkg::*;
();

	// Request side
	ramAdrsT adrs;
	ramDataT wd;
	// Access this cycle
	logic sel;
	// High read, low write
	logic rdCmd;

	// Return side, valid two cycles after a read issue
	ramDataT rd;
	logic rdValid;

	// Burst engine drives requests
	modport engine (
		output adrs, wd, sel, rdCmd,
		input rd, rdValid
	);

	// Pin driver takes every cycle with sel high
	modport phy (
		input adrs, wd, sel, rdCmd,
		output rd, rdValid
	);

endinterface

`default_nettype wire

// ==== rtl/sramFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sramFifo
	import sramPkg::*;
#(
	parameter type payloadT = logic
)(
	input wire logic iMemClk,
	input wire logic rstN,
	input wire logic push,
	input wire payloadT pushData,
	input wire logic pop,
	output payloadT popData,
	output logic full,
	output logic empty,
	output logic [FifoCountWidth-1:0] count
);

	// --------------------------------------
	// Storage and pointers
	// --------------------------------------
	payloadT mem [FifoDepth];
	logic [FifoPtrWidth-1:0] wrPtrQ;
	logic [FifoPtrWidth-1:0] rdPtrQ;
	logic [FifoCountWidth-1:0] countQ;
	logic doPush;
	logic doPop;

	// Strobes ignored at the limits
	assign doPush = push & ~full;
	assign doPop = pop & ~empty;

	assign full = (countQ == FifoCountWidth'(FifoDepth));
	assign empty = (countQ == '0);
	assign count = countQ;

	// First-word fall-through head
	assign popData = mem[rdPtrQ];

	// Pointer and level tracking
	always_ff @(posedge iMemClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtrQ <= '0;
			rdPtrQ <= '0;
			countQ <= '0;
		end
		else
		begin
			// Power-of-two depth, pointers wrap on their own
			if (doPush)
				wrPtrQ <= wrPtrQ + 1'b1;
			if (doPop)
				rdPtrQ <= rdPtrQ + 1'b1;
			if (doPush && !doPop)
				countQ <= countQ + 1'b1;
			else if (doPop && !doPush)
				countQ <= countQ - 1'b1;
		end
	end

	// Entry write
	always_ff @(posedge iMemClk)
	begin
		if (doPush)
			mem[wrPtrQ] <= pushData;
	end

endmodule

`default_nettype wire

// ==== rtl/sramPhy.sv ====
`timescale 1ns/1ps
`default_nettype none

// SRAM pin truth table, WE wins over OE
//   WE CE OE
//    x  H  x  deselected, bus released
//    H  L  H  output disabled
//    H  L  L  read, SRAM drives DQ
//    L  L  x  write, controller drives DQ
module sramPhy
	import sramPkg::*;
(
	sramCmdIf.phy bus,
	output ramAdrsT memAdrs,
	output logic memOeN,
	output logic memWeN,
	output logic memCeN,
	inout wire ramDataT memDq,
	input wire logic iMemClk,
	input wire logic rstN
);

	// --------------------------------------
	// Pin registers
	// --------------------------------------
	ramDataT wdQ;
	logic wrAccess;
	logic rdAccess;

	// Decode of the bus request
	assign wrAccess = bus.sel & ~bus.rdCmd;
	assign rdAccess = bus.sel & bus.rdCmd;

	// Controls start deselected
	always_ff @(posedge iMemClk or negedge rstN)
	begin
		if (!rstN)
		begin
			memCeN <= 1'b1;
			memWeN <= 1'b1;
			memOeN <= 1'b1;
		end
		else
		begin
			memCeN <= ~bus.sel;
			memWeN <= ~wrAccess;
			// Never low together with WE
			memOeN <= ~rdAccess;
		end
	end

	// Address and write byte follow the bus
	always_ff @(posedge iMemClk)
	begin
		memAdrs <= bus.adrs;
		wdQ <= bus.wd;
	end

	// Drive DQ only while a write sits on the pins
	assign memDq = (!memWeN) ? wdQ : 'z;

	// --------------------------------------
	// Read return
	// --------------------------------------
	// OE low is the read marker one stage on
	always_ff @(posedge iMemClk or negedge rstN)
	begin
		if (!rstN)
			bus.rdValid <= 1'b0;
		else
			bus.rdValid <= ~memOeN;
	end

	// Sample the SRAM byte at the end of the read cycle
	always_ff @(posedge iMemClk)
	begin
		if (!memOeN)
			bus.rd <= memDq;
	end

endmodule

`default_nettype wire

// ==== rtl/sramBurstEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module sramBurstEngine
	import sramPkg::*;
(
	input wire logic iMemClk,
	input wire logic rstN,
	// Command
	input wire logic cmdValid,
	input wire logic cmdRead,
	input wire ramAdrsT cmdAdrs,
	input wire logic [BurstLenWidth-1:0] cmdLen,
	output logic busy,
	// Write FIFO head
	input wire logic wrEmpty,
	input wire ramDataT wrHead,
	output logic wrPop,
	// Read FIFO side
	input wire logic [FifoCountWidth-1:0] rdCount,
	output logic rdPush,
	output readBeatT rdBeat,
	// Per-cycle SRAM access
	sramCmdIf.engine bus
);

	// --------------------------------------
	// Burst state
	// --------------------------------------
	logic activeQ;
	logic dirReadQ;
	ramAdrsT curAdrsQ;
	// Beats left minus one
	logic [BurstLenWidth-1:0] beatsLeftQ;
	// Reads issued and not yet in the read FIFO
	logic [FifoCountWidth-1:0] inFlightQ;

	logic accept;
	logic issue;
	logic rdIssue;
	logic rdCredit;
	logic [FifoCountWidth:0] pendingReads;

	// Address of each read on its way back
	ramAdrsT adrsPipeQ [PhyReadLatency];

	// Busy until issued writes are done or reads have landed
	assign busy = activeQ | (inFlightQ != '0);

	// Commands while busy are dropped
	assign accept = cmdValid & ~busy;

	// Room check counts the FIFO and reads still in the pipe
	assign pendingReads = {1'b0, rdCount} + {1'b0, inFlightQ};
	assign rdCredit = (pendingReads < (FifoCountWidth + 1)'(FifoDepth));

	// One beat per cycle at most
	// Writes wait for data, reads wait for space
	assign issue = activeQ & (dirReadQ ? rdCredit : ~wrEmpty);
	assign rdIssue = issue & dirReadQ;

	// Write byte leaves the FIFO as its beat goes out
	assign wrPop = issue & ~dirReadQ;

	// --------------------------------------
	// Bus request
	// --------------------------------------
	assign bus.sel = issue;
	assign bus.rdCmd = dirReadQ;
	assign bus.adrs = curAdrsQ;
	assign bus.wd = wrHead;

	// Sequencer
	always_ff @(posedge iMemClk or negedge rstN)
	begin
		if (!rstN)
		begin
			activeQ <= 1'b0;
			dirReadQ <= 1'b0;
			curAdrsQ <= '0;
			beatsLeftQ <= '0;
		end
		else if (accept)
		begin
			activeQ <= 1'b1;
			dirReadQ <= cmdRead;
			curAdrsQ <= cmdAdrs;
			beatsLeftQ <= cmdLen;
		end
		else if (issue)
		begin
			// Wraps modulo 2^19 on its own
			curAdrsQ <= curAdrsQ + 1'b1;
			beatsLeftQ <= beatsLeftQ - 1'b1;
			// Last beat out
			if (beatsLeftQ == '0)
				activeQ <= 1'b0;
		end
	end

	// Read credit accounting
	always_ff @(posedge iMemClk or negedge rstN)
	begin
		if (!rstN)
			inFlightQ <= '0;
		else
		begin
			case ({rdIssue, rdPush})
				2'b10: inFlightQ <= inFlightQ + 1'b1;
				2'b01: inFlightQ <= inFlightQ - 1'b1;
				default: inFlightQ <= inFlightQ;
			endcase
		end
	end

	// --------------------------------------
	// Read return pairing
	// --------------------------------------
	// Shifts every cycle to stay aligned with the phy
	always_ff @(posedge iMemClk)
	begin
		adrsPipeQ[0] <= bus.adrs;
		for (int i = 1; i < PhyReadLatency; i++)
		begin
			adrsPipeQ[i] <= adrsPipeQ[i-1];
		end
	end

	// Data and its address go into the read FIFO together
	assign rdPush = bus.rdValid;
	assign rdBeat = '{adrs: adrsPipeQ[PhyReadLatency-1], data: bus.rd};

endmodule

`default_nettype wire

// ==== rtl/sramBurstTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module sramBurstTop
	import sramPkg::*;
(
	input wire logic iMemClk,
	input wire logic rstN,
	// Burst command
	input wire logic cmdValid,
	input wire logic cmdRead,
	input wire ramAdrsT cmdAdrs,
	input wire logic [BurstLenWidth-1:0] cmdLen,
	output logic busy,
	// Write data
	input wire logic wrStrobe,
	input wire ramDataT wrData,
	output logic wrFull,
	// Read data
	input wire logic rdPop,
	output logic rdAvail,
	output ramAdrsT rdAdrs,
	output ramDataT rdData,
	// SRAM pins
	output ramAdrsT memAdrs,
	output logic memOeN,
	output logic memWeN,
	output logic memCeN,
	inout wire ramDataT memDq
);

	// --------------------------------------
	// Internal nets
	// --------------------------------------
	logic wrEmpty;
	ramDataT wrHead;
	logic wrPop;
	logic rdPush;
	readBeatT rdBeat;
	logic rdEmpty;
	readBeatT rdHead;
	logic [FifoCountWidth-1:0] rdCount;

	sramCmdIf cmdBus_i ();

	// Client bytes waiting for write beats
	sramFifo #(
		.payloadT(ramDataT)
	) wrFifo_i (
		.iMemClk(iMemClk),
		.rstN(rstN),
		.push(wrStrobe),
		.pushData(wrData),
		.pop(wrPop),
		.popData(wrHead),
		.full(wrFull),
		.empty(wrEmpty),
		.count()
	);

	// Tagged read beats, engine credit keeps it from overflowing
	sramFifo #(
		.payloadT(readBeatT)
	) rdFifo_i (
		.iMemClk(iMemClk),
		.rstN(rstN),
		.push(rdPush),
		.pushData(rdBeat),
		.pop(rdPop),
		.popData(rdHead),
		.full(),
		.empty(rdEmpty),
		.count(rdCount)
	);

	sramBurstEngine sramBurstEngine_i (
		.iMemClk(iMemClk),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmdRead(cmdRead),
		.cmdAdrs(cmdAdrs),
		.cmdLen(cmdLen),
		.busy(busy),
		.wrEmpty(wrEmpty),
		.wrHead(wrHead),
		.wrPop(wrPop),
		.rdCount(rdCount),
		.rdPush(rdPush),
		.rdBeat(rdBeat),
		.bus(cmdBus_i.engine)
	);

	sramPhy sramPhy_i (
		.bus(cmdBus_i.phy),
		.memAdrs(memAdrs),
		.memOeN(memOeN),
		.memWeN(memWeN),
		.memCeN(memCeN),
		.memDq(memDq),
		.iMemClk(iMemClk),
		.rstN(rstN)
	);

	// Read FIFO head to the client
	assign rdAvail = ~rdEmpty;
	assign rdAdrs = rdHead.adrs;
	assign rdData = rdHead.data;

endmodule

`default_nettype wire

// ==== sim/sramModel.sv ====
`timescale 1ns/1ps
`default_nettype none

// Behavioural async SRAM, 512K x 8, pins only
module sramModel
	import sramPkg::*;
(
	input wire ramAdrsT memAdrs,
	input wire logic memCeN,
	input wire logic memWeN,
	input wire logic memOeN,
	inout wire ramDataT memDq
);

	// --------------------------------------
	// Storage
	// --------------------------------------
	ramDataT mem [2**RamAdrsWidth];
	logic readDrive;

	// Fill from the whole address, no X on unwritten reads
	initial
	begin
		for (int i = 0; i < 2**RamAdrsWidth; i++)
		begin
			mem[i] = ramDataT'(i ^ (i >> 8) ^ (i >> 16));
		end
	end

	// Read drive, WE wins over OE
	assign readDrive = ~memCeN & ~memOeN & memWeN;
	assign memDq = readDrive ? mem[memAdrs] : 'z;

	// Write once the pins have settled after an edge
	always
	begin
		@(memAdrs or memDq or memWeN or memCeN);
		#1;
		if (!memCeN && !memWeN)
			mem[memAdrs] = memDq;
	end

endmodule

`default_nettype wire

// ==== sim/sramBurst_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

// Pin protocol rules, bound into each sramPhy
module sramBurstAsserts
	import sramPkg::*;
(
	input wire logic iMemClk,
	input wire logic rstN,
	input wire logic memOeN,
	input wire logic memWeN,
	input wire ramDataT memDq,
	input wire logic sel,
	input wire logic rdCmd,
	input wire logic rdValid
);

	// Failures seen, read by the testbench top
	int failCount = 0;

	// --------------------------------------
	// Rules
	// --------------------------------------
	// Never write and read enable together
	weOeExclusive: assert property (@(posedge iMemClk) disable iff (!rstN)
		!memWeN |-> memOeN)
	else
	begin
		$error("memWeN and memOeN low together");
		failCount++;
	end

	// Phy off the bus while the SRAM drives it
	dqNotDriven: assert property (@(posedge iMemClk) disable iff (!rstN)
		!memOeN |-> (memWeN && !$isunknown(memDq)))
	else
	begin
		$error("memDq contended during a read");
		failCount++;
	end

	// Read return two cycles after issue, no more and no less
	rdLatency: assert property (@(posedge iMemClk) disable iff (!rstN)
		rdValid == $past(sel & rdCmd, 2))
	else
	begin
		$error("rdValid out of step with read issue");
		failCount++;
	end

endmodule

bind sramPhy sramBurstAsserts sramBurstAsserts_i (
	.iMemClk(iMemClk),
	.rstN(rstN),
	.memOeN(memOeN),
	.memWeN(memWeN),
	.memDq(memDq),
	.sel(bus.sel),
	.rdCmd(bus.rdCmd),
	.rdValid(bus.rdValid)
);

`default_nettype wire

// ==== sim/sramBurstTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sramBurstTb
	import sramPkg::*;
();

	// --------------------------------------
	// DUT signals
	// --------------------------------------
	logic iMemClk;
	logic rstN;
	logic cmdValid;
	logic cmdRead;
	ramAdrsT cmdAdrs;
	logic [BurstLenWidth-1:0] cmdLen;
	logic busy;
	logic wrStrobe;
	ramDataT wrData;
	logic wrFull;
	logic rdPop;
	logic rdAvail;
	ramAdrsT rdAdrs;
	ramDataT rdData;
	ramAdrsT memAdrs;
	logic memOeN;
	logic memWeN;
	logic memCeN;
	wire ramDataT memDq;

	// Scoreboard of every byte written
	ramDataT mirror [int];
	int errorCount;
	int testCount;
	// Cycles with CE low on the pins
	int pinBeats = 0;

	sramBurstTop sramBurstTop_i (.*);

	sramModel sramModel_i (
		.memAdrs(memAdrs),
		.memCeN(memCeN),
		.memWeN(memWeN),
		.memOeN(memOeN),
		.memDq(memDq)
	);

	// 100 ns clock
	initial iMemClk = 1'b0;
	always #50 iMemClk = ~iMemClk;

	always @(posedge iMemClk)
	begin
		if (rstN && !memCeN)
			pinBeats <= pinBeats + 1;
	end

	// --------------------------------------
	// Helpers
	// --------------------------------------
	task automatic expectBit(input string name, input logic actual, input logic exp);
		bitMatch: assert (actual === exp)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, actual);
			errorCount++;
		end
	endtask

	task automatic expectCount(input string name, input int actual, input int exp);
		countMatch: assert (actual == exp)
		else
		begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, actual);
			errorCount++;
		end
	endtask

	// One-cycle command strobe, called on a falling edge
	task automatic sendCmd(input logic read, input ramAdrsT adrs, input int beats);
		cmdValid = 1'b1;
		cmdRead = read;
		cmdAdrs = adrs;
		cmdLen = BurstLenWidth'(beats - 1);
		@(negedge iMemClk);
		cmdValid = 1'b0;
	endtask

	task automatic waitIdle();
		int n;
		n = 0;
		while (busy && n < 4000)
		begin
			@(negedge iMemClk);
			n++;
		end
		if (busy)
		begin
			$display("Burst never finished, busy stuck high");
			errorCount++;
		end
		// Last write beat still sits on the pins for one cycle
		@(negedge iMemClk);
	endtask

	// Random bytes for a write burst already started
	task automatic pushBytes(input ramAdrsT start, input int beats, input int maxGap);
		ramDataT b;
		ramAdrsT a;
		int gap;
		for (int k = 0; k < beats; k++)
		begin
			b = ramDataT'($urandom);
			a = ramAdrsT'(start + k);
			while (wrFull)
				@(negedge iMemClk);
			// Burst cannot end before its last byte
			expectBit("busy", busy, 1'b1);
			wrStrobe = 1'b1;
			wrData = b;
			mirror[int'(a)] = b;
			@(negedge iMemClk);
			wrStrobe = 1'b0;
			gap = (maxGap > 0) ? int'($urandom_range(maxGap, 0)) : 0;
			repeat (gap) @(negedge iMemClk);
		end
	endtask

	// Drain read beats, checking tag and data
	task automatic popBeats(input ramAdrsT start, input int beats);
		ramAdrsT a;
		int n;
		for (int k = 0; k < beats; k++)
		begin
			a = ramAdrsT'(start + k);
			n = 0;
			while (!rdAvail && n < 1000)
			begin
				@(negedge iMemClk);
				n++;
			end
			if (!rdAvail)
			begin
				$display("Read beat %0d never arrived", k);
				errorCount++;
				return;
			end
			adrsMatch: assert (rdAdrs === a)
			else
			begin
				$display("CHECK FAILED rdAdrs expected %h actual %h", a, rdAdrs);
				errorCount++;
			end
			dataMatch: assert (rdData === mirror[int'(a)])
			else
			begin
				$display("CHECK FAILED rdData expected %h actual %h", mirror[int'(a)], rdData);
				errorCount++;
			end
			// Byte landed at its own pin address
			memMatch: assert (sramModel_i.mem[a] === mirror[int'(a)])
			else
			begin
				$display("CHECK FAILED mem[%h] expected %h actual %h",
					a, mirror[int'(a)], sramModel_i.mem[a]);
				errorCount++;
			end
			rdPop = 1'b1;
			@(negedge iMemClk);
			rdPop = 1'b0;
		end
	endtask

	task automatic endTest(input string name, input int errBefore);
		testCount++;
		$display("Test %0d %s: %s, %0d errors", testCount, name,
			(errorCount == errBefore) ? "ok" : "wrong", errorCount - errBefore);
	endtask

	// --------------------------------------
	// Watchdog
	// --------------------------------------
	initial
	begin
		int limitCycles;
		// All beats at 4 cycles each, margin for gaps and stalls
		limitCycles = (16 * 2 + 40 * 2 + 20 * 2 + 8 * 2 + 10 * 2 + 4 * 2) * 4 + 2000;
		#(limitCycles * 100);
		$display("Watchdog expired after %0d cycles", limitCycles);
		$display("** FAIL **");
		$finish;
	end

	// --------------------------------------
	// Tests
	// --------------------------------------
	initial
	begin
		int e;
		int beatsBefore;
		ramAdrsT start;
		ramAdrsT other;
		int assertFails;
		void'($urandom(62));
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmdRead = 1'b0;
		cmdAdrs = '0;
		cmdLen = '0;
		wrStrobe = 1'b0;
		wrData = '0;
		rdPop = 1'b0;
		errorCount = 0;
		testCount = 0;
		repeat (5) @(negedge iMemClk);
		rstN = 1'b1;
		@(negedge iMemClk);

		// Pins deselected, no activity
		e = errorCount;
		expectBit("memCeN", memCeN, 1'b1);
		expectBit("memWeN", memWeN, 1'b1);
		expectBit("memOeN", memOeN, 1'b1);
		expectBit("busy", busy, 1'b0);
		expectBit("rdAvail", rdAvail, 1'b0);
		expectBit("wrFull", wrFull, 1'b0);
		endTest("reset", e);

		// Write then read the same 16 bytes
		e = errorCount;
		other = ramAdrsT'($urandom);
		sendCmd(1'b0, other, 16);
		pushBytes(other, 16, 0);
		waitIdle();
		sendCmd(1'b1, other, 16);
		popBeats(other, 16);
		waitIdle();
		endTest("round trip", e);

		// Read FIFO full stalls the engine
		e = errorCount;
		start = 19'h12340;
		sendCmd(1'b0, start, 40);
		pushBytes(start, 40, 0);
		waitIdle();
		beatsBefore = pinBeats;
		sendCmd(1'b1, start, 40);
		repeat (60) @(negedge iMemClk);
		expectCount("read beats at stall", pinBeats - beatsBefore, FifoDepth);
		expectBit("busy", busy, 1'b1);
		expectBit("rdAvail", rdAvail, 1'b1);
		popBeats(start, 40);
		waitIdle();
		expectCount("read beats", pinBeats - beatsBefore, 40);
		endTest("read back-pressure", e);

		// Sparse write data
		e = errorCount;
		start = ramAdrsT'($urandom);
		sendCmd(1'b0, start, 20);
		pushBytes(start, 20, 5);
		waitIdle();
		sendCmd(1'b1, start, 20);
		popBeats(start, 20);
		waitIdle();
		endTest("write starvation", e);

		// Three below the top, wraps to 0
		e = errorCount;
		start = ramAdrsT'((1 << RamAdrsWidth) - 3);
		sendCmd(1'b0, start, 8);
		pushBytes(start, 8, 0);
		waitIdle();
		sendCmd(1'b1, start, 8);
		popBeats(start, 8);
		waitIdle();
		endTest("address wrap", e);

		// Second command dropped while the first waits for data
		e = errorCount;
		start = 19'h00100;
		beatsBefore = pinBeats;
		sendCmd(1'b0, start, 10);
		expectBit("busy", busy, 1'b1);
		sendCmd(1'b0, other, 4);
		pushBytes(start, 10, 0);
		waitIdle();
		expectCount("write beats", pinBeats - beatsBefore, 10);
		sendCmd(1'b1, other, 4);
		popBeats(other, 4);
		waitIdle();
		sendCmd(1'b1, start, 10);
		popBeats(start, 10);
		waitIdle();
		endTest("command while busy", e);

		assertFails = sramBurstTop_i.sramPhy_i.sramBurstAsserts_i.failCount;
		$display("Tests %0d, check errors %0d, assertion failures %0d",
			testCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sramBurst.f ====
rtl/sramPkg.sv
rtl/sramCmdIf.sv
rtl/sramFifo.sv
rtl/sramPhy.sv
rtl/sramBurstEngine.sv
rtl/sramBurstTop.sv
sim/sramModel.sv
sim/sramBurst_asserts.sv
sim/sramBurstTb.sv

// ==== Makefile ====
# Verilator flow for the SRAM burst controller

VERILATOR ?= verilator
TOP := sramBurstTb
FILELIST := sramBurst.f
BUILD_DIR := obj_dir
LOG := sim.log
LINT_FLAGS := --lint-only --timing --assert
BUILD_FLAGS := --binary --timing --assert -j 0
SIM_ARGS := +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
